//--- sim.f
cache_pkg.sv
direct_mapped_cache.sv
mem_arbiter.sv
separate_caches.sv
tb_mem_model.sv
tb_separate_caches.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the cache subsystem testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_separate_caches -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_separate_caches > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- tb_separate_caches.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the split L1 cache subsystem.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_separate_caches
    import cache_pkg::*;
;

    localparam int num_tests  = 6;
    localparam int wait_limit = 200;  // Cycles allowed for any single handshake.

    logic CLK;
    logic arst_n;
    logic icache_req_valid, icache_req_ready, icache_rsp_valid, icache_ctrl_done;
    logic dcache_req_valid, dcache_req_ready, dcache_rsp_valid, dcache_ctrl_done;
    bus_req_t icache_req, dcache_req, mem_req;
    cache_ctrl_t icache_ctrl, dcache_ctrl;
    logic [word_width-1:0] icache_rsp_rdata, dcache_rsp_rdata, mem_rsp_rdata;
    logic mem_req_valid, mem_req_ready, mem_rsp_valid;
    logic [word_width-1:0] peek_addr, peek_data;

    logic [31:0] lfsr_q = 32'h7419;
    int pass_count = 0;
    int fail_count = 0;
    bus_req_t mem_log [$];  // Every request the memory accepts.

    separate_caches u_separate_caches (.*);

    tb_mem_model u_mem (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req       (mem_req),
        .rsp_valid (mem_rsp_valid),
        .rsp_rdata (mem_rsp_rdata),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    always #5 CLK = ~CLK;

    always @(negedge CLK) begin
        if (mem_req_valid && mem_req_ready) begin
            mem_log.push_back(mem_req);
        end
    end

    initial begin
        #(num_tests * 2000);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [word_width-1:0] init_word(input logic [word_width-1:0] addr);
        return {24'h0, addr[9:2]} ^ 32'hA5A50000;
    endfunction

    function automatic bus_req_t make_req(input logic [word_width-1:0] addr,
                                          input logic [word_width-1:0] wdata,
                                          input logic we);
        bus_req_t r;
        r.addr.raw = addr;
        r.wdata    = wdata;
        r.we       = we;
        return r;
    endfunction

    task automatic draw_word(output logic [word_width-1:0] w);
        for (int i = 0; i < word_width; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[i]   = lfsr_q[0];
        end
    endtask

    task automatic check_word(input string name, input logic [word_width-1:0] exp,
                              input logic [word_width-1:0] got);
        if (got !== exp) begin
            $display("Fail %s exp %h got %h", name, exp, got);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_req(input string name, input bus_req_t exp, input bus_req_t got);
        if (got !== exp) begin
            $display("Fail %s exp %h got %h", name, exp, got);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic peek_mem(input logic [word_width-1:0] addr,
                            output logic [word_width-1:0] data);
        peek_addr = addr;
        #1;
        data = peek_data;
    endtask

    // One request on either cache; lat counts cycles from acceptance to response.
    task automatic access(input logic use_d, input bus_req_t req,
                          output logic [word_width-1:0] rdata, output int lat);
        int   n;
        logic seen;
        @(posedge CLK);
        #1;
        if (use_d) begin
            dcache_req       = req;
            dcache_req_valid = 1'b1;
        end else begin
            icache_req       = req;
            icache_req_valid = 1'b1;
        end
        n    = 0;
        seen = 1'b0;
        while (!seen && n < wait_limit) begin
            @(negedge CLK);
            n++;
            seen = use_d ? dcache_req_ready : icache_req_ready;
        end
        @(posedge CLK);
        #1;
        dcache_req_valid = 1'b0;
        icache_req_valid = 1'b0;
        rdata = '0;
        lat   = 0;
        if (!seen) begin
            $display("Request to the %s was never accepted", use_d ? "dcache" : "icache");
            fail_count++;
        end else begin
            seen = 1'b0;
            while (!seen && lat < wait_limit) begin
                @(negedge CLK);
                lat++;
                seen  = use_d ? dcache_rsp_valid : icache_rsp_valid;
                rdata = use_d ? dcache_rsp_rdata : icache_rsp_rdata;
            end
            if (!seen) begin
                $display("No response from the %s within %0d cycles",
                         use_d ? "dcache" : "icache", wait_limit);
                fail_count++;
            end
        end
    endtask

    // Raises a command, waits for done, then drops it and waits for done to clear.
    task automatic run_command(input logic use_d, input cache_ctrl_t cmd, output int cycles);
        int   n;
        logic dn;
        @(posedge CLK);
        #1;
        if (use_d) dcache_ctrl = cmd;
        else icache_ctrl = cmd;
        n  = 0;
        dn = 1'b0;
        while (!dn && n < wait_limit) begin
            @(negedge CLK);
            n++;
            dn = use_d ? dcache_ctrl_done : icache_ctrl_done;
        end
        cycles = n;
        if (!dn) begin
            $display("Command on the %s never reported done", use_d ? "dcache" : "icache");
            fail_count++;
        end
        @(posedge CLK);
        #1;
        dcache_ctrl = '0;
        icache_ctrl = '0;
        n = 0;
        while (dn && n < wait_limit) begin
            @(negedge CLK);
            n++;
            dn = use_d ? dcache_ctrl_done : icache_ctrl_done;
        end
        if (dn) begin
            $display("Done stayed high after the command was dropped");
            fail_count++;
        end
    endtask

    task automatic test_icache_miss_hit();
        logic [word_width-1:0] rd;
        int lat;
        access(1'b0, make_req(32'h104, '0, 1'b0), rd, lat);
        check_word("icache_rsp_rdata", init_word(32'h104), rd);
        access(1'b0, make_req(32'h104, '0, 1'b0), rd, lat);
        check_word("icache_rsp_rdata", init_word(32'h104), rd);
        check_word("hit_latency", 32'd1, lat);
    endtask

    task automatic test_dcache_write_read();
        logic [word_width-1:0] w, rd;
        int lat;
        draw_word(w);
        access(1'b1, make_req(32'h208, w, 1'b1), rd, lat);
        access(1'b1, make_req(32'h208, '0, 1'b0), rd, lat);
        check_word("dcache_rsp_rdata", w, rd);
        peek_mem(32'h208, rd);
        check_word("mem_word", init_word(32'h208), rd);  // Still the old word in memory.
    endtask

    task automatic test_eviction();
        logic [word_width-1:0] w1, w2, rd;
        int lat;
        draw_word(w1);
        draw_word(w2);
        access(1'b1, make_req(32'h010, w1, 1'b1), rd, lat);
        mem_log.delete();
        access(1'b1, make_req(32'h050, w2, 1'b1), rd, lat);  // Same index, other tag.
        check_word("writeback_count", 32'd1, mem_log.size());
        if (mem_log.size() > 0) begin
            check_req("mem_req", make_req(32'h010, w1, 1'b1), mem_log[0]);
        end
        peek_mem(32'h010, rd);
        check_word("mem_word", w1, rd);
        access(1'b1, make_req(32'h010, '0, 1'b0), rd, lat);
        check_word("dcache_rsp_rdata", w1, rd);
    endtask

    task automatic test_flush();
        logic [word_width-1:0] w, rd;
        int lat, cyc;
        draw_word(w);
        access(1'b1, make_req(32'h318, w, 1'b1), rd, lat);
        run_command(1'b1, '{flush: 1'b1, clear: 1'b0}, cyc);
        peek_mem(32'h318, rd);
        check_word("mem_word", w, rd);
        access(1'b0, make_req(32'h318, '0, 1'b0), rd, lat);
        check_word("icache_rsp_rdata", w, rd);
    endtask

    task automatic test_clear();
        logic [word_width-1:0] w, rd;
        int lat, cyc;
        draw_word(w);
        access(1'b1, make_req(32'h224, w, 1'b1), rd, lat);
        run_command(1'b1, '{flush: 1'b0, clear: 1'b1}, cyc);
        check_word("clear_cycles", 32'd18, cyc);  // One start cycle and sixteen lines before done.
        run_command(1'b0, '{flush: 1'b0, clear: 1'b1}, cyc);
        check_word("icache_clear_cycles", 32'd18, cyc);
        access(1'b1, make_req(32'h224, '0, 1'b0), rd, lat);
        check_word("dcache_rsp_rdata", init_word(32'h224), rd);
    endtask

    task automatic test_concurrent_miss();
        logic [word_width-1:0] i_rd, d_rd;
        int n, i_lat, d_lat;
        @(posedge CLK);
        #1;
        icache_req       = make_req(32'h3A8, '0, 1'b0);
        dcache_req       = make_req(32'h0B0, '0, 1'b0);
        icache_req_valid = 1'b1;
        dcache_req_valid = 1'b1;
        @(negedge CLK);
        if (!(icache_req_ready && dcache_req_ready)) begin
            $display("Caches were not both ready for the concurrent reads");
            fail_count++;
        end
        @(posedge CLK);
        #1;
        icache_req_valid = 1'b0;
        dcache_req_valid = 1'b0;
        n     = 0;
        i_lat = 0;
        d_lat = 0;
        while ((i_lat == 0 || d_lat == 0) && n < wait_limit) begin
            @(negedge CLK);
            n++;
            if (icache_rsp_valid) begin
                i_lat = n;
                i_rd  = icache_rsp_rdata;
            end
            if (dcache_rsp_valid) begin
                d_lat = n;
                d_rd  = dcache_rsp_rdata;
            end
        end
        if (i_lat == 0 || d_lat == 0) begin
            $display("A response to the concurrent reads never came");
            fail_count++;
        end else begin
            check_word("icache_rsp_rdata", init_word(32'h3A8), i_rd);
            check_word("dcache_rsp_rdata", init_word(32'h0B0), d_rd);
            if (d_lat >= i_lat) begin
                $display("The data response did not arrive before the instruction one");
                fail_count++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %0d errors", num, name, fail_count - errs_before);
    endtask

    initial begin
        int errs;
        CLK = 1'b0;
        arst_n = 1'b0;
        icache_req_valid = 1'b0;
        dcache_req_valid = 1'b0;
        icache_req = '0;
        dcache_req = '0;
        icache_ctrl = '0;
        dcache_ctrl = '0;
        peek_addr = '0;
        repeat (8) @(posedge CLK);
        #1;
        arst_n = 1'b1;

        errs = fail_count;
        test_icache_miss_hit();
        report_test(1, "icache miss then hit", errs);
        errs = fail_count;
        test_dcache_write_read();
        report_test(2, "dcache write then read", errs);
        errs = fail_count;
        test_eviction();
        report_test(3, "eviction write-back", errs);
        errs = fail_count;
        test_flush();
        report_test(4, "flush", errs);
        errs = fail_count;
        test_clear();
        report_test(5, "clear", errs);
        errs = fail_count;
        test_concurrent_miss();
        report_test(6, "concurrent misses", errs);

        $display("Checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench memory. Fixed three cycle latency, valid/ready
// request port and a peek port for checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import cache_pkg::*;
(
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  bus_req_t              req,
    output logic                  rsp_valid,
    output logic [word_width-1:0] rsp_rdata,
    input  logic [word_width-1:0] peek_addr,
    output logic [word_width-1:0] peek_data
);

    logic [word_width-1:0] mem_q [256];
    bus_req_t              req_q;
    logic                  busy;   // Set from acceptance until the response cycle ends.
    logic [1:0]            cnt;
    logic [7:0]            req_idx;

    assign req_ready = !busy;
    assign req_idx   = req_q.addr.raw[9:2];
    assign peek_data = mem_q[peek_addr[9:2]];

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem_q[i] = 32'(i) ^ 32'hA5A50000;  // Word address mixed with a marker.
        end
    end

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            cnt       <= 2'd0;
            rsp_valid <= 1'b0;
            rsp_rdata <= '0;
        end else if (req_valid && req_ready) begin
            busy  <= 1'b1;
            cnt   <= 2'd0;
            req_q <= req;
        end else if (busy) begin
            if (rsp_valid) begin
                rsp_valid <= 1'b0;
                busy      <= 1'b0;
            end else begin
                cnt <= cnt + 2'd1;
                if (cnt == 2'd1) begin
                    rsp_valid <= 1'b1;  // Seen by the requester three edges after acceptance.
                    rsp_rdata <= mem_q[req_idx];
                    if (req_q.we) begin
                        mem_q[req_idx] <= req_q.wdata;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- separate_caches.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Split L1 cache subsystem. Instruction and data cache
// behind one shared memory port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module separate_caches
    import cache_pkg::*;
(
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  icache_req_valid,
    output logic                  icache_req_ready,
    input  bus_req_t              icache_req,
    output logic                  icache_rsp_valid,
    output logic [word_width-1:0] icache_rsp_rdata,
    input  cache_ctrl_t           icache_ctrl,
    output logic                  icache_ctrl_done,
    input  logic                  dcache_req_valid,
    output logic                  dcache_req_ready,
    input  bus_req_t              dcache_req,
    output logic                  dcache_rsp_valid,
    output logic [word_width-1:0] dcache_rsp_rdata,
    input  cache_ctrl_t           dcache_ctrl,
    output logic                  dcache_ctrl_done,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output bus_req_t              mem_req,
    input  logic                  mem_rsp_valid,
    input  logic [word_width-1:0] mem_rsp_rdata
);

    // Memory side of each cache, toward the arbiter.
    logic                  imem_req_valid;
    logic                  imem_req_ready;
    bus_req_t              imem_req;
    logic                  imem_rsp_valid;
    logic [word_width-1:0] imem_rsp_rdata;
    logic                  dmem_req_valid;
    logic                  dmem_req_ready;
    bus_req_t              dmem_req;
    logic                  dmem_rsp_valid;
    logic [word_width-1:0] dmem_rsp_rdata;

    direct_mapped_cache u_icache (
        .CLK            (CLK),
        .arst_n         (arst_n),
        .proc_req_valid (icache_req_valid),
        .proc_req_ready (icache_req_ready),
        .proc_req       (icache_req),
        .proc_rsp_valid (icache_rsp_valid),
        .proc_rsp_rdata (icache_rsp_rdata),
        .ctrl           (icache_ctrl),
        .ctrl_done      (icache_ctrl_done),
        .mem_req_valid  (imem_req_valid),
        .mem_req_ready  (imem_req_ready),
        .mem_req        (imem_req),
        .mem_rsp_valid  (imem_rsp_valid),
        .mem_rsp_rdata  (imem_rsp_rdata)
    );

    direct_mapped_cache u_dcache (
        .CLK            (CLK),
        .arst_n         (arst_n),
        .proc_req_valid (dcache_req_valid),
        .proc_req_ready (dcache_req_ready),
        .proc_req       (dcache_req),
        .proc_rsp_valid (dcache_rsp_valid),
        .proc_rsp_rdata (dcache_rsp_rdata),
        .ctrl           (dcache_ctrl),
        .ctrl_done      (dcache_ctrl_done),
        .mem_req_valid  (dmem_req_valid),
        .mem_req_ready  (dmem_req_ready),
        .mem_req        (dmem_req),
        .mem_rsp_valid  (dmem_rsp_valid),
        .mem_rsp_rdata  (dmem_rsp_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .CLK              (CLK),
        .arst_n           (arst_n),
        .icache_req_valid (imem_req_valid),
        .icache_req_ready (imem_req_ready),
        .icache_req       (imem_req),
        .icache_rsp_valid (imem_rsp_valid),
        .icache_rsp_rdata (imem_rsp_rdata),
        .dcache_req_valid (dmem_req_valid),
        .dcache_req_ready (dmem_req_ready),
        .dcache_req       (dmem_req),
        .dcache_rsp_valid (dmem_rsp_valid),
        .dcache_rsp_rdata (dmem_rsp_rdata),
        .mem_req_valid    (mem_req_valid),
        .mem_req_ready    (mem_req_ready),
        .mem_req          (mem_req),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_rdata    (mem_rsp_rdata)
    );

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory arbiter. Shares one memory port between the
// instruction and data cache, data cache first.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import cache_pkg::*;
(
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  icache_req_valid,
    output logic                  icache_req_ready,
    input  bus_req_t              icache_req,
    output logic                  icache_rsp_valid,
    output logic [word_width-1:0] icache_rsp_rdata,
    input  logic                  dcache_req_valid,
    output logic                  dcache_req_ready,
    input  bus_req_t              dcache_req,
    output logic                  dcache_rsp_valid,
    output logic [word_width-1:0] dcache_rsp_rdata,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output bus_req_t              mem_req,
    input  logic                  mem_rsp_valid,
    input  logic [word_width-1:0] mem_rsp_rdata
);

    logic [1:0] grant;  // Held from the first request cycle until the response.
    logic [1:0] sel;
    logic       busy;   // A transfer is accepted and its response is pending.

    // With no grant held, pick combinationally so no cycle is lost.
    always_comb begin
        sel = grant;
        if (grant == grant_none) begin
            if (dcache_req_valid) begin
                sel = grant_dcache;
            end else if (icache_req_valid) begin
                sel = grant_icache;
            end
        end
    end

    assign mem_req_valid = !busy && (((sel == grant_dcache) && dcache_req_valid) ||
                                     ((sel == grant_icache) && icache_req_valid));
    assign mem_req       = (sel == grant_icache) ? icache_req : dcache_req;

    assign icache_req_ready = !busy && mem_req_ready && (sel == grant_icache);
    assign dcache_req_ready = !busy && mem_req_ready && (sel == grant_dcache);

    // Read data goes to both; only the granted side sees the valid pulse.
    assign icache_rsp_valid = mem_rsp_valid && (grant == grant_icache);
    assign dcache_rsp_valid = mem_rsp_valid && (grant == grant_dcache);
    assign icache_rsp_rdata = mem_rsp_rdata;
    assign dcache_rsp_rdata = mem_rsp_rdata;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            grant <= grant_none;
            busy  <= 1'b0;
        end else if (mem_rsp_valid) begin
            grant <= grant_none;
            busy  <= 1'b0;
        end else begin
            if (mem_req_valid) begin
                grant <= sel;  // Keeps the grant through memory back-pressure.
            end
            if (mem_req_valid && mem_req_ready) begin
                busy <= 1'b1;
            end
        end
    end

    // A grant once given stays with its cache until the response.
    a_grant_held: assert property (@(posedge CLK) disable iff (!arst_n)
        (grant != grant_none) && !mem_rsp_valid |=> grant == $past(grant));

    a_rsp_granted: assert property (@(posedge CLK) disable iff (!arst_n)
        mem_rsp_valid |-> (grant != grant_none) && busy);

endmodule

`default_nettype wire

//--- direct_mapped_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped write-back cache, 16 one-word lines,
// with miss handling, flush walk and clear walk.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module direct_mapped_cache
    import cache_pkg::*;
(
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  proc_req_valid,
    output logic                  proc_req_ready,
    input  bus_req_t              proc_req,
    output logic                  proc_rsp_valid,
    output logic [word_width-1:0] proc_rsp_rdata,
    input  cache_ctrl_t           ctrl,
    output logic                  ctrl_done,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output bus_req_t              mem_req,
    input  logic                  mem_rsp_valid,
    input  logic [word_width-1:0] mem_rsp_rdata
);

    cache_state_e state;
    bus_req_t     req_q;                    // The one request in flight.
    logic [index_width-1:0] walk_idx;
    logic         mem_wait;                 // Memory request accepted, response pending.

    logic [num_lines-1:0]  valid_q;
    logic [num_lines-1:0]  dirty_q;
    logic [tag_width-1:0]  tag_mem  [num_lines];
    logic [word_width-1:0] data_mem [num_lines];

    logic [index_width-1:0] in_idx;
    logic [index_width-1:0] req_idx;
    logic [index_width-1:0] line_idx;
    logic accept;
    logic hit;
    logic victim_dirty;
    logic walk_dirty;
    logic walk_last;

    logic                   line_wr_en;
    logic [index_width-1:0] line_wr_idx;
    logic [tag_width-1:0]   line_wr_tag;
    logic [word_width-1:0]  line_wr_data;

    assign in_idx       = proc_req.addr.fields.index;
    assign req_idx      = req_q.addr.fields.index;
    assign line_idx     = (state == flush_walk) ? walk_idx : req_idx;
    assign hit          = valid_q[in_idx] && (tag_mem[in_idx] == proc_req.addr.fields.tag);
    assign victim_dirty = valid_q[in_idx] && dirty_q[in_idx];
    assign walk_dirty   = valid_q[walk_idx] && dirty_q[walk_idx];
    assign walk_last    = (walk_idx == index_width'(num_lines - 1));

    // Commands take the cache away from the processor while they run.
    assign proc_req_ready = (state == idle) && !ctrl.flush && !ctrl.clear;
    assign accept         = proc_req_valid && proc_req_ready;
    assign proc_rsp_valid = (state == hit_resp);
    assign proc_rsp_rdata = data_mem[req_idx];
    assign ctrl_done      = (state == done);

    always_comb begin
        mem_req_valid = 1'b0;
        if (!mem_wait) begin
            mem_req_valid = (state == writeback) || (state == fill) ||
                            ((state == flush_walk) && walk_dirty);
        end
    end

    // Victim address is rebuilt from the stored tag and the line index.
    always_comb begin
        mem_req.we    = (state != fill);
        mem_req.wdata = data_mem[line_idx];
        if (state == fill) begin
            mem_req.addr = req_q.addr;
        end else begin
            mem_req.addr.fields.tag    = tag_mem[line_idx];
            mem_req.addr.fields.index  = line_idx;
            mem_req.addr.fields.offset = 2'b00;
        end
    end

    // A line is one word, so a write miss installs the line whole.
    always_comb begin
        line_wr_en   = 1'b0;
        line_wr_idx  = req_idx;
        line_wr_tag  = req_q.addr.fields.tag;
        line_wr_data = req_q.wdata;
        if (accept && proc_req.we && (hit || !victim_dirty)) begin
            line_wr_en   = 1'b1;
            line_wr_idx  = in_idx;
            line_wr_tag  = proc_req.addr.fields.tag;
            line_wr_data = proc_req.wdata;
        end else if (mem_rsp_valid && (state == writeback) && req_q.we) begin
            line_wr_en = 1'b1;
        end else if (mem_rsp_valid && (state == fill)) begin
            line_wr_en   = 1'b1;
            line_wr_data = mem_rsp_rdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q <= proc_req;
        end
        if (line_wr_en) begin
            tag_mem[line_wr_idx]  <= line_wr_tag;
            data_mem[line_wr_idx] <= line_wr_data;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            valid_q  <= '0;
            dirty_q  <= '0;
            walk_idx <= '0;
            mem_wait <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                mem_wait <= 1'b1;
            end
            if (mem_rsp_valid) begin
                mem_wait <= 1'b0;
            end
            case (state)
                idle: begin
                    walk_idx <= '0;
                    if (ctrl.clear) begin
                        state <= clear_walk;
                    end else if (ctrl.flush) begin
                        state <= flush_walk;
                    end else if (accept) begin
                        if (!hit && victim_dirty) begin
                            state <= writeback;
                        end else if (hit || proc_req.we) begin
                            state <= hit_resp;
                        end else begin
                            state <= fill;
                        end
                    end
                end
                hit_resp: state <= idle;
                writeback: begin
                    if (mem_rsp_valid) begin
                        dirty_q[req_idx] <= 1'b0;
                        state <= req_q.we ? hit_resp : fill;
                    end
                end
                fill: begin
                    if (mem_rsp_valid) begin
                        state <= hit_resp;
                    end
                end
                flush_walk: begin
                    if (walk_dirty) begin
                        if (mem_rsp_valid) begin
                            dirty_q[walk_idx] <= 1'b0;  // Line stays valid, now clean.
                        end
                    end else if (walk_last) begin
                        state <= done;
                    end else begin
                        walk_idx <= walk_idx + 1'b1;
                    end
                end
                clear_walk: begin
                    valid_q[walk_idx] <= 1'b0;
                    dirty_q[walk_idx] <= 1'b0;
                    walk_idx <= walk_idx + 1'b1;
                    if (walk_last) begin
                        state <= done;
                    end
                end
                done: begin
                    if (!ctrl.flush && !ctrl.clear) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
            if (line_wr_en) begin
                valid_q[line_wr_idx] <= 1'b1;
                dirty_q[line_wr_idx] <= (state != fill);  // A fill leaves the line clean.
            end
        end
    end

    // A response only ends an accepted request or a finished memory transfer.
    a_rsp_after_req: assert property (@(posedge CLK) disable iff (!arst_n)
        proc_rsp_valid |-> $past(accept || mem_rsp_valid));

    a_mem_req_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> $stable(mem_req));

endmodule

`default_nettype wire

//--- cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache package. Sizes, address union, bus and control
// structs and the cache controller state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cache_pkg;

    localparam int word_width  = 32;
    localparam int num_lines   = 16;
    localparam int index_width = 4;
    localparam int tag_width   = 26;

    // Arbiter grant encoding.
    localparam logic [1:0] grant_none   = 2'd0;
    localparam logic [1:0] grant_icache = 2'd1;
    localparam logic [1:0] grant_dcache = 2'd2;

    // One byte address, read either as a bus word or as cache fields.
    typedef union packed {
        logic [word_width-1:0] raw;
        struct packed {
            logic [tag_width-1:0]   tag;
            logic [index_width-1:0] index;
            logic [1:0]             offset;  // Always zero, accesses are word aligned.
        } fields;
    } cache_addr_u;

    // Word request, used on the processor and the memory side alike.
    typedef struct packed {
        cache_addr_u           addr;
        logic [word_width-1:0] wdata;
        logic                  we;
    } bus_req_t;

    // Cache commands, each held as a level until ctrl_done.
    typedef struct packed {
        logic flush;
        logic clear;
    } cache_ctrl_t;

    typedef enum logic [2:0] {
        idle,
        hit_resp,
        writeback,
        fill,
        flush_walk,
        clear_walk,
        done
    } cache_state_e;

endpackage

`default_nettype wire
